// File: project.f
source/cpu_stage_pkg.sv
source/mmu_pkg.sv
source/tlb_lookup.sv
source/seg_limit_check.sv
source/operand_swap.sv
source/mem_stage.sv
bench/mem_stage_sva.sv
bench/mem_stage_tb.sv

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
    import cpu_stage_pkg::*, mmu_pkg::*;
();

    localparam int PERIOD = 100;
    localparam int CYCLES = 400;

    logic clk, rst, clr, valid_in, IE_in, is_br_in;
    logic [OPSIZE_W-1:0] opsize_in, opsize_out, exp_size;
    logic [MEM_RW_W-1:0] mem_rw;
    logic [ADDR_W-1:0] mem_addr, mem_addr_end, seg_limit, eip_in, eip_out, dest_addr;
    logic [DATA_W-1:0] reg1, reg2, op1_val, op2_val, exp_op1, exp_op2;
    logic [SEG_W-1:0] seg;
    logic [IMM_W-1:0] imm;
    logic [OPSEL_W-1:0] op1_sel, op2_sel;
    logic [DEST_TYPE_W-1:0] dest_type;
    logic [DEST_IDX_W-1:0] dest_idx;
    logic [IE_TYPE_W-1:0] IE_type_in, IE_type_out, exp_type;
    logic [ALUK_W-1:0] aluk_in, aluk_out, exp_aluk;
    logic [VP_TABLE_W-1:0] vp_table;
    logic [PF_TABLE_W-1:0] pf_table;
    logic [TLB_ENTRIES-1:0] entry_v, entry_p, entry_rw;
    logic valid_out, IE_out, dest_is_reg, dest_is_seg, dest_is_mem, is_br_out;
    logic exp_valid, exp_ie, exp_reg, exp_seg, exp_mem, exp_br, loaded;
    logic [ADDR_W-1:0] exp_eip, exp_dest;
    logic [31:0] lcg_state = 32'h247ce93e;

    mem_stage mem_stage_inst (.*);

    bind mem_stage mem_stage_sva sva_inst (
        .clk         (clk),
        .rst         (rst),
        .clr         (clr),
        .valid_out   (valid_out),
        .IE_out      (IE_out),
        .IE_type_out (IE_type_out),
        .dest_is_reg (dest_is_reg),
        .dest_is_seg (dest_is_seg),
        .dest_is_mem (dest_is_mem)
    );

    // two LCG steps, upper halves only since the low bits repeat quickly
    function automatic logic [31:0] next_rand();
        logic [31:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    function automatic logic [DATA_W-1:0] expected_operand(input logic [OPSEL_W-1:0] sel);
        logic [DATA_W-1:0] v;
        int bytes;
        case (sel)
            OPSEL_REG1: v = reg1;
            OPSEL_REG2: v = reg2;
            OPSEL_SEG:  v = {48'd0, seg};
            OPSEL_IMM:  v = {{32{imm[31]}}, imm};
            OPSEL_EIP:  v = {32'd0, eip_in};
            default:    v = '0;
        endcase
        bytes = 1 << opsize_in;
        if (bytes < 8) v = v & ((64'd1 << (8 * bytes)) - 64'd1);
        return v;
    endfunction

    task automatic wait_edge(input bit rising);
        bit timed_out;
        timed_out = 1'b0;
        fork
            begin
                if (rising) @(posedge clk);
                else @(negedge clk);
            end
            begin
                #(2 * PERIOD);
                timed_out = 1'b1;
            end
        join_any
        disable fork;
        if (timed_out) begin
            $display("clock edge did not arrive within two periods");
            $display("Errors found");
            $fatal(1, "clock timeout");
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("Error: %s got %h expected %h", name, got, want);
            $display("Errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_assertions();
        if (mem_stage_inst.sva_inst.fail_count != 0) begin
            $display("bound assertion failed %0d times", mem_stage_inst.sva_inst.fail_count);
            $display("Errors found");
            $fatal(1, "assertion failure");
        end
    endtask

    task automatic drive_inputs(input int cyc);
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] addr_end;
        logic [IE_TYPE_W-1:0] ie_type;
        r = next_rand();
        if (cyc == 1) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                // index in the low VP bits keeps every entry unique
                vp_table[i*VPN_W +: VPN_W] <= {r[31:15], 3'(i)};
                pf_table[i*PFN_W +: PFN_W] <= r[19:0];
                r = next_rand();
            end
            entry_v  <= r[7:0] | 8'h0f;
            entry_p  <= r[15:8] | 8'h33;
            entry_rw <= r[23:16];
            r = next_rand();
        end
        rst      <= cyc == 0 || cyc == 200;
        clr      <= r[3:0] == 4'd0;
        valid_in <= r[5:4] != 2'd0;
        mem_rw   <= r[11:6] % 3;
        // about half the addresses land on a table VP
        addr = r[12] ? {vp_table[r[15:13]*VPN_W +: VPN_W], r[27:16]} : next_rand();
        addr_end = addr + r[30:28];
        mem_addr     <= addr;
        mem_addr_end <= addr_end;
        r = next_rand();
        seg_limit <= addr_end + r[3:0] - 32'd4;
        opsize_in <= r[5:4];
        op1_sel   <= r[8:6];
        op2_sel   <= r[11:9];
        dest_type <= r[13:12];
        dest_idx  <= r[16:14];
        aluk_in   <= r[21:17];
        is_br_in  <= r[22];
        // faults from earlier stages are rare
        ie_type = {r[24:23] == 2'b11, r[24:23] == 2'b10, r[27:25] == 3'd0, r[30:28] == 3'd0};
        IE_type_in <= ie_type;
        IE_in      <= r[31] | (|ie_type);
        reg1   <= {next_rand(), next_rand()};
        reg2   <= {next_rand(), next_rand()};
        seg    <= 16'(next_rand());
        imm    <= next_rand();
        eip_in <= next_rand();
    endtask

    // next state of the stage register from the inputs it is about to sample
    task automatic model_capture();
        logic [PFN_W-1:0] pf;
        logic hit, ro, access, miss, tprot, sprot;
        hit = 1'b0;
        ro = 1'b0;
        pf = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_v[i] && entry_p[i] && vp_table[i*VPN_W +: VPN_W] == mem_addr[31:12]) begin
                hit = 1'b1;
                pf = pf_table[i*PFN_W +: PFN_W];
                ro = !entry_rw[i];
            end
        end
        access = mem_rw != MEM_NONE;
        miss = access && !hit;
        tprot = access && hit && ro && mem_rw == MEM_WRITE;
        sprot = access && mem_addr_end >= seg_limit;
        if (rst || clr) begin
            {exp_valid, exp_ie, exp_reg, exp_seg, exp_mem} = '0;
        end else if (!valid_in) begin
            exp_valid = 1'b0;
        end else begin
            exp_valid = 1'b1;
            exp_ie = IE_in | miss | tprot | sprot;
            exp_type = {IE_type_in[3:2], IE_type_in[1] | miss, IE_type_in[0] | tprot | sprot};
            {exp_size, exp_eip, exp_aluk, exp_br} = {opsize_in, eip_in, aluk_in, is_br_in};
            exp_op1 = expected_operand(op1_sel);
            exp_op2 = expected_operand(op2_sel);
            exp_reg = dest_type == DEST_REG;
            exp_seg = dest_type == DEST_SEG;
            exp_mem = dest_type == DEST_MEM;
            if (exp_reg || exp_seg) exp_dest = {29'd0, dest_idx};
            else if (exp_mem && hit) exp_dest = {pf, mem_addr[11:0]};
            else exp_dest = '0;
            loaded = 1'b1;
        end
    endtask

    task automatic check_outputs();
        check_value("valid_out", valid_out, exp_valid);
        check_value("IE_out", IE_out, exp_ie);
        check_value("dest_flags", {dest_is_reg, dest_is_seg, dest_is_mem},
                    {exp_reg, exp_seg, exp_mem});
        if (loaded) begin
            check_value("IE_type_out", IE_type_out, exp_type);
            check_value("op1_val", op1_val, exp_op1);
            check_value("op2_val", op2_val, exp_op2);
            check_value("dest_addr", dest_addr, exp_dest);
            check_value("eip_out", eip_out, exp_eip);
            check_value("opsize_out", opsize_out, exp_size);
            check_value("aluk_out", aluk_out, exp_aluk);
            check_value("is_br_out", is_br_out, exp_br);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        loaded = 1'b0;
        {clr, valid_in, IE_in, is_br_in, opsize_in, mem_rw} = '0;
        {mem_addr, mem_addr_end, seg_limit, eip_in, reg1, reg2, seg, imm} = '0;
        {op1_sel, op2_sel, dest_type, dest_idx, IE_type_in, aluk_in} = '0;
        {vp_table, pf_table, entry_v, entry_p, entry_rw} = '0;
        model_capture();
        for (int cyc = 0; cyc < CYCLES; cyc++) begin
            wait_edge(1'b1);
            drive_inputs(cyc);
            // outputs are settled by the falling edge
            wait_edge(1'b0);
            check_outputs();
            check_assertions();
            model_capture();
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: bench/mem_stage_sva.sv
`timescale 1ns/1ps

module mem_stage_sva
    import cpu_stage_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 clr,
    input logic                 valid_out,
    input logic                 IE_out,
    input logic [IE_TYPE_W-1:0] IE_type_out,
    input logic                 dest_is_reg,
    input logic                 dest_is_seg,
    input logic                 dest_is_mem
);

    int fail_count = 0;

    // a reset or flush leaves a bubble behind it
    flush_gives_bubble: assert property (@(posedge clk) (rst || clr) |=> !valid_out)
        else begin
            $error("valid_out high in the cycle after rst or clr");
            fail_count++;
        end

    // a valid instruction with a typed exception must flag it
    type_implies_ie: assert property (@(posedge clk) disable iff (rst)
        (valid_out && |IE_type_out) |-> IE_out)
        else begin
            $error("IE_type_out bit set while IE_out is low");
            fail_count++;
        end

    dest_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({dest_is_reg, dest_is_seg, dest_is_mem}))
        else begin
            $error("more than one destination flag high");
            fail_count++;
        end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import cpu_stage_pkg::*, mmu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clr,
    input  logic                   valid_in,
    input  logic [OPSIZE_W-1:0]    opsize_in,
    input  logic [MEM_RW_W-1:0]    mem_rw,
    input  logic [ADDR_W-1:0]      mem_addr,
    input  logic [ADDR_W-1:0]      mem_addr_end,
    input  logic [ADDR_W-1:0]      seg_limit,
    input  logic [DATA_W-1:0]      reg1,
    input  logic [DATA_W-1:0]      reg2,
    input  logic [SEG_W-1:0]       seg,
    input  logic [IMM_W-1:0]       imm,
    input  logic [ADDR_W-1:0]      eip_in,
    input  logic [OPSEL_W-1:0]     op1_sel,
    input  logic [OPSEL_W-1:0]     op2_sel,
    input  logic [DEST_TYPE_W-1:0] dest_type,
    input  logic [DEST_IDX_W-1:0]  dest_idx,
    input  logic                   IE_in,
    input  logic [IE_TYPE_W-1:0]   IE_type_in,
    input  logic [ALUK_W-1:0]      aluk_in,
    input  logic                   is_br_in,
    input  logic [VP_TABLE_W-1:0]  vp_table,
    input  logic [PF_TABLE_W-1:0]  pf_table,
    input  logic [TLB_ENTRIES-1:0] entry_v,
    input  logic [TLB_ENTRIES-1:0] entry_p,
    input  logic [TLB_ENTRIES-1:0] entry_rw,
    output logic                   valid_out,
    output logic [ADDR_W-1:0]      eip_out,
    output logic                   IE_out,
    output logic [IE_TYPE_W-1:0]   IE_type_out,
    output logic [OPSIZE_W-1:0]    opsize_out,
    output logic [DATA_W-1:0]      op1_val,
    output logic [DATA_W-1:0]      op2_val,
    output logic [ADDR_W-1:0]      dest_addr,
    output logic                   dest_is_reg,
    output logic                   dest_is_seg,
    output logic                   dest_is_mem,
    output logic [ALUK_W-1:0]      aluk_out,
    output logic                   is_br_out
);

    logic                 mem_access;
    logic                 mem_write;
    logic [ADDR_W-1:0]    phys_addr;
    logic                 tlb_miss_raw;
    logic                 tlb_prot_raw;
    logic                 tlb_miss;
    logic                 tlb_prot;
    logic                 seg_prot;
    logic [DATA_W-1:0]    op1_next;
    logic [DATA_W-1:0]    op2_next;
    logic [ADDR_W-1:0]    dest_addr_next;
    logic                 dest_is_reg_next;
    logic                 dest_is_seg_next;
    logic                 dest_is_mem_next;
    logic                 ie_next;
    logic [IE_TYPE_W-1:0] ie_type_next;

    assign mem_access = mem_rw != MEM_NONE;
    assign mem_write  = mem_rw == MEM_WRITE;

    tlb_lookup tlb_lookup_inst (
        .mem_addr  (mem_addr),
        .write     (mem_write),
        .vp_table  (vp_table),
        .pf_table  (pf_table),
        .entry_v   (entry_v),
        .entry_p   (entry_p),
        .entry_rw  (entry_rw),
        .phys_addr (phys_addr),
        .tlb_miss  (tlb_miss_raw),
        .tlb_prot  (tlb_prot_raw)
    );

    seg_limit_check seg_limit_check_inst (
        .mem_addr_end (mem_addr_end),
        .seg_limit    (seg_limit),
        .access       (mem_access),
        .seg_prot     (seg_prot)
    );

    operand_swap operand_swap_inst (
        .reg1        (reg1),
        .reg2        (reg2),
        .seg         (seg),
        .imm         (imm),
        .eip         (eip_in),
        .phys_addr   (phys_addr),
        .op1_sel     (op1_sel),
        .op2_sel     (op2_sel),
        .opsize      (opsize_in),
        .dest_type   (dest_type),
        .dest_idx    (dest_idx),
        .op1_val     (op1_next),
        .op2_val     (op2_next),
        .dest_addr   (dest_addr_next),
        .dest_is_reg (dest_is_reg_next),
        .dest_is_seg (dest_is_seg_next),
        .dest_is_mem (dest_is_mem_next)
    );

    // tlb faults only matter for an instruction that touches memory
    assign tlb_miss = mem_access & tlb_miss_raw;
    assign tlb_prot = mem_access & tlb_prot_raw;

    // merge new faults into what earlier stages reported
    always_comb begin
        ie_type_next          = IE_type_in;
        ie_type_next[IE_PROT] = IE_type_in[IE_PROT] | seg_prot | tlb_prot;
        ie_type_next[IE_PAGE] = IE_type_in[IE_PAGE] | tlb_miss;
    end

    assign ie_next = IE_in | seg_prot | tlb_prot | tlb_miss;

    // stage register, flush clears the control bits only
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            valid_out   <= 1'b0;
            IE_out      <= 1'b0;
            dest_is_reg <= 1'b0;
            dest_is_seg <= 1'b0;
            dest_is_mem <= 1'b0;
        end else if (!valid_in) begin
            // bubble, payload holds
            valid_out <= 1'b0;
        end else begin
            valid_out   <= 1'b1;
            eip_out     <= eip_in;
            IE_out      <= ie_next;
            IE_type_out <= ie_type_next;
            opsize_out  <= opsize_in;
            op1_val     <= op1_next;
            op2_val     <= op2_next;
            dest_addr   <= dest_addr_next;
            dest_is_reg <= dest_is_reg_next;
            dest_is_seg <= dest_is_seg_next;
            dest_is_mem <= dest_is_mem_next;
            aluk_out    <= aluk_in;
            is_br_out   <= is_br_in;
        end
    end

endmodule

// File: source/operand_swap.sv
`timescale 1ns/1ps

module operand_swap
    import cpu_stage_pkg::*;
(
    input  logic [DATA_W-1:0]      reg1,
    input  logic [DATA_W-1:0]      reg2,
    input  logic [SEG_W-1:0]       seg,
    input  logic [IMM_W-1:0]       imm,
    input  logic [ADDR_W-1:0]      eip,
    input  logic [ADDR_W-1:0]      phys_addr,
    input  logic [OPSEL_W-1:0]     op1_sel,
    input  logic [OPSEL_W-1:0]     op2_sel,
    input  logic [OPSIZE_W-1:0]    opsize,
    input  logic [DEST_TYPE_W-1:0] dest_type,
    input  logic [DEST_IDX_W-1:0]  dest_idx,
    output logic [DATA_W-1:0]      op1_val,
    output logic [DATA_W-1:0]      op2_val,
    output logic [ADDR_W-1:0]      dest_addr,
    output logic                   dest_is_reg,
    output logic                   dest_is_seg,
    output logic                   dest_is_mem
);

    logic [DATA_W-1:0] size_mask;
    logic [DATA_W-1:0] seg_ext;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] eip_ext;

    assign seg_ext = {{(DATA_W-SEG_W){1'b0}}, seg};
    // immediate is signed, everything else zero-extends
    assign imm_ext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
    assign eip_ext = {{(DATA_W-ADDR_W){1'b0}}, eip};

    function automatic logic [DATA_W-1:0] pick(
        input logic [OPSEL_W-1:0] sel,
        input logic [DATA_W-1:0]  r1,
        input logic [DATA_W-1:0]  r2,
        input logic [DATA_W-1:0]  s,
        input logic [DATA_W-1:0]  i,
        input logic [DATA_W-1:0]  e
    );
        case (sel)
            OPSEL_REG1: pick = r1;
            OPSEL_REG2: pick = r2;
            OPSEL_SEG:  pick = s;
            OPSEL_IMM:  pick = i;
            OPSEL_EIP:  pick = e;
            default:    pick = '0;
        endcase
    endfunction

    always_comb begin
        case (opsize)
            OPSIZE_8:  size_mask = {{(DATA_W-8){1'b0}}, {8{1'b1}}};
            OPSIZE_16: size_mask = {{(DATA_W-16){1'b0}}, {16{1'b1}}};
            OPSIZE_32: size_mask = {{(DATA_W-32){1'b0}}, {32{1'b1}}};
            OPSIZE_64: size_mask = {DATA_W{1'b1}};
            default:   size_mask = {DATA_W{1'b1}};
        endcase
    end

    assign op1_val = pick(op1_sel, reg1, reg2, seg_ext, imm_ext, eip_ext) & size_mask;
    assign op2_val = pick(op2_sel, reg1, reg2, seg_ext, imm_ext, eip_ext) & size_mask;

    // destination decode
    assign dest_is_reg = dest_type == DEST_REG;
    assign dest_is_seg = dest_type == DEST_SEG;
    assign dest_is_mem = dest_type == DEST_MEM;

    always_comb begin
        case (dest_type)
            DEST_REG, DEST_SEG: dest_addr = {{(ADDR_W-DEST_IDX_W){1'b0}}, dest_idx};
            DEST_MEM:           dest_addr = phys_addr;
            DEST_NONE:          dest_addr = '0;
            default:            dest_addr = '0;
        endcase
    end

endmodule

// File: source/seg_limit_check.sv
`timescale 1ns/1ps

module seg_limit_check
    import cpu_stage_pkg::*;
(
    input  logic [ADDR_W-1:0] mem_addr_end,
    input  logic [ADDR_W-1:0] seg_limit,
    input  logic              access,
    output logic              seg_prot
);

    logic end_gt_limit;
    logic end_eq_limit;
    logic past_limit;

    // unsigned magnitude compare of the last byte against the limit
    assign end_gt_limit = mem_addr_end > seg_limit;
    assign end_eq_limit = mem_addr_end == seg_limit;

    // the limit itself is already outside the segment
    assign past_limit = end_gt_limit | end_eq_limit;

    // only a real read or write can fault
    assign seg_prot = access & past_limit;

endmodule

// File: source/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup
    import cpu_stage_pkg::*, mmu_pkg::*;
(
    input  logic [ADDR_W-1:0]      mem_addr,
    input  logic                   write,
    input  logic [VP_TABLE_W-1:0]  vp_table,
    input  logic [PF_TABLE_W-1:0]  pf_table,
    input  logic [TLB_ENTRIES-1:0] entry_v,
    input  logic [TLB_ENTRIES-1:0] entry_p,
    input  logic [TLB_ENTRIES-1:0] entry_rw,
    output logic [ADDR_W-1:0]      phys_addr,
    output logic                   tlb_miss,
    output logic                   tlb_prot
);

    logic [VPN_W-1:0]       vpn;
    logic [TLB_ENTRIES-1:0] match;
    logic [PFN_W-1:0]       pfn;
    logic                   hit;

    assign vpn = mem_addr[ADDR_W-1 -: VPN_W];

    // one comparator per entry
    genvar gi;
    generate
        for (gi = 0; gi < TLB_ENTRIES; gi++) begin : g_cmp
            assign match[gi] = entry_v[gi] & entry_p[gi]
                               & (vp_table[gi*VPN_W +: VPN_W] == vpn);
        end
    endgenerate

    // match is one-hot on a legal table, so an OR of the gated frames
    // acts as the select mux
    always_comb begin
        pfn = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                pfn = pfn | pf_table[i*PFN_W +: PFN_W];
            end
        end
    end

    assign hit      = |match;
    assign tlb_miss = ~hit;

    // write into a read-only page
    assign tlb_prot = write & |(match & ~entry_rw);

    // zero on a miss so a faulting access never carries a stale frame
    assign phys_addr = hit ? {pfn, mem_addr[PAGE_OFFSET_W-1:0]} : '0;

endmodule

// File: source/mmu_pkg.sv
package mmu_pkg;

    // fully associative, all entries compared in parallel
    localparam int TLB_ENTRIES = 8;

    // 4 KB pages
    localparam int PAGE_OFFSET_W = 12;

    // virtual page number is the top of the linear address
    localparam int VPN_W = 20;

    // physical frame number joins the page offset to form the
    // physical address
    localparam int PFN_W = 20;

    // table widths when the entries are packed side by side,
    // entry i sits at [i*VPN_W +: VPN_W]
    localparam int VP_TABLE_W = TLB_ENTRIES * VPN_W;
    localparam int PF_TABLE_W = TLB_ENTRIES * PFN_W;

endpackage

// File: source/cpu_stage_pkg.sv
package cpu_stage_pkg;

    // datapath widths
    localparam int DATA_W     = 64;
    localparam int ADDR_W     = 32;
    localparam int SEG_W      = 16;
    localparam int IMM_W      = 32;
    localparam int DEST_IDX_W = 3;
    localparam int ALUK_W     = 5;
    localparam int IE_TYPE_W  = 4;

    // operand size, number of low bytes kept
    localparam int OPSIZE_W = 2;
    localparam logic [OPSIZE_W-1:0] OPSIZE_8  = 2'd0;
    localparam logic [OPSIZE_W-1:0] OPSIZE_16 = 2'd1;
    localparam logic [OPSIZE_W-1:0] OPSIZE_32 = 2'd2;
    localparam logic [OPSIZE_W-1:0] OPSIZE_64 = 2'd3;

    // operand source select, unlisted codes give zero
    localparam int OPSEL_W = 3;
    localparam logic [OPSEL_W-1:0] OPSEL_REG1 = 3'd0;
    localparam logic [OPSEL_W-1:0] OPSEL_REG2 = 3'd1;
    localparam logic [OPSEL_W-1:0] OPSEL_SEG  = 3'd2;
    localparam logic [OPSEL_W-1:0] OPSEL_IMM  = 3'd3;
    localparam logic [OPSEL_W-1:0] OPSEL_EIP  = 3'd4;

    localparam int DEST_TYPE_W = 2;
    localparam logic [DEST_TYPE_W-1:0] DEST_NONE = 2'd0;
    localparam logic [DEST_TYPE_W-1:0] DEST_REG  = 2'd1;
    localparam logic [DEST_TYPE_W-1:0] DEST_SEG  = 2'd2;
    localparam logic [DEST_TYPE_W-1:0] DEST_MEM  = 2'd3;

    localparam int MEM_RW_W = 2;
    localparam logic [MEM_RW_W-1:0] MEM_NONE  = 2'd0;
    localparam logic [MEM_RW_W-1:0] MEM_READ  = 2'd1;
    localparam logic [MEM_RW_W-1:0] MEM_WRITE = 2'd2;

    // bit positions in IE_type, upper two bits come from earlier stages
    localparam int IE_PROT = 0;
    localparam int IE_PAGE = 1;

endpackage
